/* engine_merge_data.f */
+incdir+design
design/merge_pkg.sv
design/stream_if.sv
design/packet_fifo.sv
design/response_router.sv
design/merge_configure.sv
design/merge_generator.sv
design/engine_merge_data.sv
verification/tb_engine_merge_data.sv

/* Makefile */
# Verilator simulation of the merge engine

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_engine_merge_data
FILELIST = engine_merge_data.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* verification/tb_engine_merge_data.sv */
// Engine merge data testbench

`include "merge_consts.svh"

module tb_engine_merge_data;
    timeunit 1ns;
    timeprecision 100ps;
    import merge_pkg::*;

    localparam int NUM_JOBS           = 6;
    localparam int MAX_WORDS          = 12;
    localparam int TIMEOUT            = 2000;
    localparam int HOLD_LOW           = 40;
    localparam int ORDER_MIXED        = 0;
    localparam int ORDER_ENGINE_FIRST = 1;
    localparam int RDY_HIGH           = 0;
    localparam int RDY_RANDOM         = 1;
    localparam int RDY_HOLD           = 2;

    logic         ap_clk;
    logic         areset_csr_engine;
    logic         engine_valid_i;
    merge_data_t  engine_data_i;
    logic         engine_ready_o;
    logic         memory_valid_i;
    packet_kind_t memory_kind_i;
    merge_data_t  memory_data_i;
    logic         memory_ready_o;
    logic         request_valid_o;
    merge_data_t  request_data_o;
    logic         request_ready_i;
    logic         done_o;

    // Job table with one row per merge job
    merge_mask_t job_mask  [NUM_JOBS];
    int          job_count [NUM_JOBS];
    int          job_order [NUM_JOBS];
    int          job_ready [NUM_JOBS];
    merge_data_t eng_words [NUM_JOBS][MAX_WORDS];
    merge_data_t mem_words [NUM_JOBS][MAX_WORDS];
    merge_data_t exp_words [NUM_JOBS][MAX_WORDS];

    merge_data_t exp_q [$];
    int          ready_mode = RDY_HIGH;
    int          hold_cnt   = 0;

    engine_merge_data DUT (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .engine_valid_i   (engine_valid_i),
        .engine_data_i    (engine_data_i),
        .engine_ready_o   (engine_ready_o),
        .memory_valid_i   (memory_valid_i),
        .memory_kind_i    (memory_kind_i),
        .memory_data_i    (memory_data_i),
        .memory_ready_o   (memory_ready_o),
        .request_valid_o  (request_valid_o),
        .request_data_o   (request_data_o),
        .request_ready_i  (request_ready_i),
        .done_o           (done_o)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
            abort_run();
        end
    endtask

    // Expected word built bit by bit from the mask
    function automatic merge_data_t merge_expect(input merge_mask_t m, input merge_data_t e,
                                                 input merge_data_t d);
        merge_data_t r;
        for (int b = 0; b < `MERGE_DATA_W; b++) begin
            r[b] = m[b % `MERGE_HALF_W] ? e[b] : d[b];
        end
        return r;
    endfunction

    function automatic merge_data_t config_word(input int r);
        return {merge_count_t'(job_count[r]), job_mask[r]};
    endfunction

    task automatic set_row(input int r, input merge_mask_t m, input int n, input int order,
                           input int rdy);
        job_mask[r]  = m;
        job_count[r] = n;
        job_order[r] = order;
        job_ready[r] = rdy;
    endtask

    task automatic build_table();
        set_row(0, 16'hff00, 4, ORDER_MIXED, RDY_HIGH);
        set_row(1, 16'h0f0f, 12, ORDER_MIXED, RDY_HOLD);
        set_row(2, 16'ha5a5, 10, ORDER_MIXED, RDY_RANDOM);
        set_row(3, 16'h3c3c, 4, ORDER_ENGINE_FIRST, RDY_RANDOM);
        set_row(4, 16'hffff, 0, ORDER_MIXED, RDY_HIGH);
        set_row(5, 16'h00ff, 5, ORDER_MIXED, RDY_RANDOM);
        for (int r = 0; r < NUM_JOBS; r++) begin
            for (int w = 0; w < job_count[r]; w++) begin
                eng_words[r][w] = $urandom();
                mem_words[r][w] = $urandom();
                exp_words[r][w] = merge_expect(job_mask[r], eng_words[r][w], mem_words[r][w]);
            end
        end
    endtask

    // Up to two idle cycles between input words
    task automatic random_gap();
        int gap;
        gap = $urandom_range(2, 0);
        repeat (gap) begin
            @(posedge ap_clk);
            #1;
        end
    endtask

    task automatic send_engine_word(input merge_data_t d);
        int waited;
        waited         = 0;
        engine_valid_i = 1'b1;
        engine_data_i  = d;
        @(negedge ap_clk);
        while (!engine_ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout at %0t waiting for engine_ready_o", $time);
                abort_run();
            end
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        #1;
        engine_valid_i = 1'b0;
    endtask

    task automatic send_memory_word(input packet_kind_t k, input merge_data_t d);
        int waited;
        waited         = 0;
        memory_valid_i = 1'b1;
        memory_kind_i  = k;
        memory_data_i  = d;
        @(negedge ap_clk);
        while (!memory_ready_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout at %0t waiting for memory_ready_o", $time);
                abort_run();
            end
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        #1;
        memory_valid_i = 1'b0;
    endtask

    task automatic send_engine_stream(input int r);
        for (int w = 0; w < job_count[r]; w++) begin
            random_gap();
            send_engine_word(eng_words[r][w]);
        end
    endtask

    // Configuration packet ahead of the job's memory data
    task automatic send_memory_stream(input int r);
        send_memory_word(KIND_CONFIG, config_word(r));
        for (int w = 0; w < job_count[r]; w++) begin
            random_gap();
            send_memory_word(KIND_DATA, mem_words[r][w]);
        end
    endtask

    task automatic wait_done_low();
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (done_o) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout at %0t waiting for done_o to fall", $time);
                abort_run();
            end
            @(negedge ap_clk);
        end
    endtask

    task automatic wait_queue_drained();
        int waited;
        waited = 0;
        @(negedge ap_clk);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                $display("Timeout at %0t waiting for %0d request words", $time, exp_q.size());
                abort_run();
            end
            @(negedge ap_clk);
        end
    endtask

    // ------------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------------
    initial begin
        request_ready_i = 1'b1;
        forever begin : ready_drive
            logic [31:0] rnd;
            @(posedge ap_clk);
            #1;
            if (ready_mode == RDY_RANDOM) begin
                rnd             = $urandom();
                request_ready_i = rnd[0];
            end else if (ready_mode == RDY_HOLD && hold_cnt > 0) begin
                request_ready_i = 1'b0;
                hold_cnt--;
            end else begin
                request_ready_i = 1'b1;
            end
        end
    end

    // Transfer completes on the next rising edge
    initial begin
        forever begin : request_monitor
            merge_data_t want;
            @(negedge ap_clk);
            if (!areset_csr_engine && request_valid_o && request_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: request word %h arrived with none expected",
                             $time, request_data_o);
                    abort_run();
                end else begin
                    want = exp_q.pop_front();
                    check_value("request_data_o", request_data_o, want);
                end
            end
        end
    end

    task automatic run_job(input int r);
        for (int w = 0; w < job_count[r]; w++) begin
            exp_q.push_back(exp_words[r][w]);
        end
        ready_mode = job_ready[r];
        hold_cnt   = (job_ready[r] == RDY_HOLD) ? HOLD_LOW : 0;
        if (job_count[r] == 0) begin
            send_memory_word(KIND_CONFIG, config_word(r));
            repeat (12) begin
                @(negedge ap_clk);
                check_value("done_o", done_o, 1);
            end
            @(posedge ap_clk);
            #1;
        end else if (job_order[r] == ORDER_ENGINE_FIRST) begin
            send_engine_stream(r);
            // Engine words wait in their FIFO for a job
            repeat (10) begin
                @(negedge ap_clk);
                check_value("request_valid_o", request_valid_o, 0);
                check_value("done_o", done_o, 1);
            end
            @(posedge ap_clk);
            #1;
            fork
                send_memory_stream(r);
                wait_done_low();
            join
        end else begin
            fork
                send_memory_stream(r);
                send_engine_stream(r);
                wait_done_low();
            join
        end
        wait_queue_drained();
        @(negedge ap_clk);
        check_value("done_o", done_o, 1);
        @(posedge ap_clk);
        #1;
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin : main_seq
        logic [31:0] seed_ret;
        seed_ret          = $urandom(32'hd1f5_0fd6);
        areset_csr_engine = 1'b1;
        engine_valid_i    = 1'b0;
        engine_data_i     = '0;
        memory_valid_i    = 1'b0;
        memory_kind_i     = KIND_DATA;
        memory_data_i     = '0;
        build_table();
        repeat (5) @(posedge ap_clk);
        #1;
        areset_csr_engine = 1'b0;

        @(negedge ap_clk);
        check_value("done_o", done_o, 1);
        check_value("request_valid_o", request_valid_o, 0);
        check_value("engine_ready_o", engine_ready_o, 1);
        check_value("memory_ready_o", memory_ready_o, 1);
        @(posedge ap_clk);
        #1;

        for (int r = 0; r < NUM_JOBS; r++) begin
            run_job(r);
        end

        // Idle tail with ready high to expose any stray word
        ready_mode = RDY_HIGH;
        repeat (10) @(negedge ap_clk);
        $display("TB PASSED");
        $finish;
    end

endmodule : tb_engine_merge_data

/* design/engine_merge_data.sv */
// Engine merge data top

module engine_merge_data (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    // Engine response
    input  logic                   engine_valid_i,
    input  merge_pkg::merge_data_t engine_data_i,
    output logic                   engine_ready_o,
    // Memory response
    input  logic                   memory_valid_i,
    input  merge_pkg::packet_kind_t memory_kind_i,
    input  merge_pkg::merge_data_t memory_data_i,
    output logic                   memory_ready_o,
    // Request out
    output logic                   request_valid_o,
    output merge_pkg::merge_data_t request_data_o,
    input  logic                   request_ready_i,
    output logic                   done_o
);
    import merge_pkg::*;

    logic         job_valid;
    merge_mask_t  job_mask;
    merge_count_t job_count;
    logic         job_take;

    // ----------------------------------------------------------------------
    // Streams
    // ----------------------------------------------------------------------
    stream_if eng_port ();
    stream_if mem_port ();
    stream_if req_port ();
    stream_if eng_in ();
    stream_if mem_in ();
    stream_if cfg_pkt ();
    stream_if mem_data ();
    stream_if req ();

    // Engine side carries data only
    assign eng_port.valid = engine_valid_i;
    assign eng_port.kind  = KIND_DATA;
    assign eng_port.data  = engine_data_i;
    assign engine_ready_o = eng_port.ready;

    assign mem_port.valid = memory_valid_i;
    assign mem_port.kind  = memory_kind_i;
    assign mem_port.data  = memory_data_i;
    assign memory_ready_o = mem_port.ready;

    assign req_port.ready  = request_ready_i;
    assign request_valid_o = req_port.valid;
    assign request_data_o  = req_port.data;

    // ----------------------------------------------------------------------
    // Input and output buffering
    // ----------------------------------------------------------------------
    packet_fifo inst_fifo_engine_in (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (eng_port),
        .pop              (eng_in)
    );

    packet_fifo inst_fifo_memory_in (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (mem_port),
        .pop              (mem_in)
    );

    packet_fifo inst_fifo_request_out (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push             (req),
        .pop              (req_port)
    );

    // ----------------------------------------------------------------------
    // Config and merge path
    // ----------------------------------------------------------------------
    response_router inst_response_router (
        .in_pkt  (mem_in),
        .cfg_pkt (cfg_pkt),
        .data_pkt(mem_data)
    );

    merge_configure inst_merge_configure (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .cfg_pkt          (cfg_pkt),
        .job_valid_o      (job_valid),
        .job_mask_o       (job_mask),
        .job_count_o      (job_count),
        .job_take_i       (job_take)
    );

    merge_generator inst_merge_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .job_valid_i      (job_valid),
        .job_mask_i       (job_mask),
        .job_count_i      (job_count),
        .job_take_o       (job_take),
        .eng_in           (eng_in),
        .mem_data         (mem_data),
        .req              (req),
        .done_o           (done_o)
    );

endmodule : engine_merge_data

/* design/merge_generator.sv */
// Merge word generator

module merge_generator (
    input  logic                    ap_clk,
    input  logic                    areset_csr_engine,
    input  logic                    job_valid_i,
    input  merge_pkg::merge_mask_t  job_mask_i,
    input  merge_pkg::merge_count_t job_count_i,
    output logic                    job_take_o,
    stream_if.sink                  eng_in,
    stream_if.sink                  mem_data,
    stream_if.source                req,
    output logic                    done_o
);
    import merge_pkg::*;

    gen_state_t   state;
    merge_count_t remain;
    merge_mask_t  mask_q;
    merge_data_t  wide_mask;
    logic         merging;
    logic         step;
    logic         last_word;
    logic         done_q;

    assign merging   = (state == GEN_MERGE);
    assign job_take_o = (state == GEN_IDLE) & job_valid_i;

    // ----------------------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------------------
    // Each side is ready only when the other two can complete
    assign eng_in.ready   = merging & mem_data.valid & req.ready;
    assign mem_data.ready = merging & eng_in.valid & req.ready;
    assign req.valid      = merging & eng_in.valid & mem_data.valid;
    assign step           = merging & eng_in.valid & mem_data.valid & req.ready;
    assign last_word      = (remain == merge_count_t'(1));

    // Same mask in both halves
    assign wide_mask = {mask_q, mask_q};
    assign req.kind  = KIND_DATA;
    assign req.data  = (eng_in.data & wide_mask) | (mem_data.data & ~wide_mask);

    // ----------------------------------------------------------------------
    // Job control
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state  <= GEN_IDLE;
            remain <= '0;
            done_q <= 1'b1;
        end else begin
            case (state)
                GEN_IDLE: begin
                    // Zero count jobs are dropped here
                    if (job_valid_i && (job_count_i != '0)) begin
                        state  <= GEN_MERGE;
                        remain <= job_count_i;
                        done_q <= 1'b0;
                    end
                end
                GEN_MERGE: begin
                    if (step) begin
                        remain <= remain - 1'b1;
                        if (last_word) begin
                            state  <= GEN_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= GEN_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (job_take_o) begin
            mask_q <= job_mask_i;
        end
    end

    assign done_o = done_q;

endmodule : merge_generator

/* design/merge_configure.sv */
// Merge job configuration

`include "merge_consts.svh"

module merge_configure (
    input  logic                   ap_clk,
    input  logic                   areset_csr_engine,
    stream_if.sink                 cfg_pkt,
    output logic                   job_valid_o,
    output merge_pkg::merge_mask_t job_mask_o,
    output merge_pkg::merge_count_t job_count_o,
    input  logic                   job_take_i
);
    import merge_pkg::*;

    logic         job_valid_q;
    merge_mask_t  job_mask_q;
    merge_count_t job_count_q;
    logic         cfg_fire;

    // One pending job, new config waits until it is taken
    assign cfg_pkt.ready = ~job_valid_q;
    assign cfg_fire      = cfg_pkt.valid & ~job_valid_q;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            job_valid_q <= 1'b0;
        end else if (cfg_fire) begin
            job_valid_q <= 1'b1;
        end else if (job_take_i) begin
            job_valid_q <= 1'b0;
        end
    end

    // Count in upper half, mask in lower half
    always_ff @(posedge ap_clk) begin
        if (cfg_fire) begin
            job_count_q <= cfg_pkt.data[`MERGE_DATA_W-1:`MERGE_HALF_W];
            job_mask_q  <= cfg_pkt.data[`MERGE_HALF_W-1:0];
        end
    end

    assign job_valid_o = job_valid_q;
    assign job_mask_o  = job_mask_q;
    assign job_count_o = job_count_q;

endmodule : merge_configure

/* design/response_router.sv */
// Memory response router

module response_router (
    stream_if.sink   in_pkt,
    stream_if.source cfg_pkt,
    stream_if.source data_pkt
);
    import merge_pkg::*;

    logic is_config;

    assign is_config = (in_pkt.kind == KIND_CONFIG);

    // ----------------------------------------------------------------------
    // Forward path
    // ----------------------------------------------------------------------
    // Payload fans out, only the selected side sees valid
    assign cfg_pkt.valid = in_pkt.valid & is_config;
    assign cfg_pkt.kind  = in_pkt.kind;
    assign cfg_pkt.data  = in_pkt.data;

    assign data_pkt.valid = in_pkt.valid & ~is_config;
    assign data_pkt.kind  = in_pkt.kind;
    assign data_pkt.data  = in_pkt.data;

    // ----------------------------------------------------------------------
    // Back-pressure
    // ----------------------------------------------------------------------
    // Head packet waits on its own destination only
    always_comb begin
        if (is_config) begin
            in_pkt.ready = cfg_pkt.ready;
        end else begin
            in_pkt.ready = data_pkt.ready;
        end
    end

endmodule : response_router

/* design/packet_fifo.sv */
// Packet FIFO with registered output

`include "merge_consts.svh"

module packet_fifo #(
    parameter int DEPTH = `MERGE_FIFO_DEPTH
) (
    input  logic     ap_clk,
    input  logic     areset_csr_engine,
    stream_if.sink   push,
    stream_if.source pop
);
    import merge_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    packet_kind_t    kind_mem [DEPTH];
    merge_data_t     data_mem [DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            full;
    logic            empty;
    logic            do_push;
    logic            do_load;
    logic            out_valid;
    packet_kind_t    out_kind;
    merge_data_t     out_data;

    // Extra pointer bit tells full from empty
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign do_push = push.valid & ~full;
    // Refill output stage when it is empty or being drained
    assign do_load = ~empty & (~out_valid | pop.ready);

    assign push.ready = ~full;
    assign pop.valid  = out_valid;
    assign pop.kind   = out_kind;
    assign pop.data   = out_data;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_load) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (pop.ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Storage and output payload
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            kind_mem[wr_ptr[ADDR_W-1:0]] <= push.kind;
            data_mem[wr_ptr[ADDR_W-1:0]] <= push.data;
        end
        if (do_load) begin
            out_kind <= kind_mem[rd_ptr[ADDR_W-1:0]];
            out_data <= data_mem[rd_ptr[ADDR_W-1:0]];
        end
    end

endmodule : packet_fifo

/* design/stream_if.sv */
// Valid/ready packet stream

interface stream_if;
    import merge_pkg::*;

    logic         valid;
    logic         ready;
    packet_kind_t kind;
    merge_data_t  data;

    // Producer side
    modport source (
        output valid, kind, data,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid, kind, data,
        output ready
    );

endinterface : stream_if

/* design/merge_pkg.sv */
// Merge engine types

`include "merge_consts.svh"

package merge_pkg;

    // Packet and request payload
    typedef logic [`MERGE_DATA_W-1:0] merge_data_t;

    // Half word, base of mask and count
    typedef logic [`MERGE_HALF_W-1:0] merge_half_t;

    // Mask bit 1 selects engine data, 0 selects memory data
    typedef merge_half_t merge_mask_t;

    // Number of merged words in one job
    typedef merge_half_t merge_count_t;

    typedef enum logic {
        KIND_DATA   = 1'b0,
        KIND_CONFIG = 1'b1
    } packet_kind_t;

    typedef enum logic {
        GEN_IDLE  = 1'b0,
        GEN_MERGE = 1'b1
    } gen_state_t;

endpackage : merge_pkg

/* design/merge_consts.svh */
// Merge engine constants

`ifndef MERGE_CONSTS_SVH
`define MERGE_CONSTS_SVH

// Packet word width
`define MERGE_DATA_W 32

// Mask and count width, half a packet word
`define MERGE_HALF_W 16

// Default depth of every packet FIFO
`define MERGE_FIFO_DEPTH 8

`endif
